// ==== common/dsm_params.svh ====
`ifndef DSM_PARAMS_SVH
`define DSM_PARAMS_SVH

// Width M of the modulator control vector
`define VEC_W 8

// Samples per batch
`define BATCH_LEN 16

// Recursion state and leak
`define STATE_W 16
`define LEAK_SHIFT 3

// Output word and scaling of the summed states
`define OUT_W 12
`define OUT_SHIFT 1

// Derived widths
`define WEIGHT_W ($clog2(`VEC_W) + 2)
`define POS_W $clog2(`BATCH_LEN)

`endif

// ==== common/dsmPkg.sv ====
`include "dsm_params.svh"

package dsmPkg;

    // Raw control vector, one bit per modulator element
    typedef logic [`VEC_W-1:0] dsmVector_t;

    // Signed weight, twice the ones count minus VEC_W
    typedef logic signed [`WEIGHT_W-1:0] dsmWeight_t;

    // Recursion state
    typedef logic signed [`STATE_W-1:0] dsmState_t;

    // Scaled and saturated partial result, kept in the result memory
    typedef logic signed [`OUT_W-1:0] dsmResult_t;

    // Offset-binary output word
    typedef logic [`OUT_W-1:0] dsmOut_t;

endpackage

// ==== common/batchPkg.sv ====
`include "dsm_params.svh"

package batchPkg;

    // Position inside a batch
    typedef logic [`POS_W-1:0] batchPos_t;

    // One of the three rotating sample regions
    typedef logic [1:0] batchRegion_t;

    // Region in the upper bits, position below
    typedef logic [$bits(batchRegion_t)+$bits(batchPos_t)-1:0] sampleAddr_t;

    // Saturating count of batch periods since reset
    typedef logic [1:0] batchPeriod_t;

endpackage

// ==== rtl/batchSequencer.sv ====
`include "dsm_params.svh"

module batchSequencer (
    input  logic                 clkDS,
    input  logic                 rst,
    output batchPkg::sampleAddr_t writeAddr,
    output batchPkg::sampleAddr_t fwdAddr,
    output batchPkg::sampleAddr_t bwdAddr,
    output batchPkg::batchPos_t   fwdPos,
    output batchPkg::batchPos_t   bwdPos,
    output logic                 backRestart,
    output logic                 resBank,
    output logic                 valid
);
    import batchPkg::*;

    localparam batchPos_t LastPos = batchPos_t'(`BATCH_LEN - 1);
    // Read register, filter, adder and output register
    localparam int ValidDelay = 4;

    batchPos_t pos;
    batchPos_t revPos;
    batchRegion_t wrRegion;
    batchRegion_t fwdRegion;
    batchRegion_t bwdRegion;
    batchPeriod_t period;
    logic bank;
    logic batchEnd;
    logic [ValidDelay-1:0] validPipe;

    assign batchEnd = (pos == LastPos);
    assign revPos = LastPos - pos;

    // Forward reads the batch written two periods ago, (p - 2) mod 3
    assign fwdRegion = (wrRegion == 2'd2) ? 2'd0 : wrRegion + 2'd1;
    // Backward reads the batch written in the previous period
    assign bwdRegion = (wrRegion == 2'd0) ? 2'd2 : wrRegion - 2'd1;

    assign writeAddr = {wrRegion, pos};
    assign fwdAddr = {fwdRegion, pos};
    assign bwdAddr = {bwdRegion, revPos};

    assign backRestart = (pos == '0);

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            pos <= '0;
            wrRegion <= '0;
            bank <= 1'b0;
            period <= '0;
        end else begin
            pos <= batchEnd ? '0 : pos + batchPos_t'(1);
            if (batchEnd) begin
                wrRegion <= (wrRegion == 2'd2) ? 2'd0 : wrRegion + 2'd1;
                bank <= ~bank;
                if (period != 2'd3) begin
                    period <= period + 2'd1;
                end
            end
        end
    end

    // Positions and bank follow the registered read data
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            fwdPos <= '0;
            bwdPos <= '0;
            resBank <= 1'b0;
        end else begin
            fwdPos <= pos;
            bwdPos <= revPos;
            resBank <= bank;
        end
    end

    // Forward data is real from period 2 on
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[ValidDelay-2:0], period[1]};
        end
    end

    assign valid = validPipe[ValidDelay-1];

endmodule

// ==== rtl/sampleBuffer.sv ====
`include "dsm_params.svh"

module sampleBuffer (
    input  logic                 clkDS,
    input  batchPkg::sampleAddr_t writeAddr,
    input  dsmPkg::dsmVector_t    in,
    input  batchPkg::sampleAddr_t fwdAddr,
    input  batchPkg::sampleAddr_t bwdAddr,
    output dsmPkg::dsmVector_t    fwdData,
    output dsmPkg::dsmVector_t    bwdData
);
    import dsmPkg::*;
    import batchPkg::*;

    localparam int NumRegions = 3;

    dsmVector_t mem [NumRegions][`BATCH_LEN];

    batchRegion_t wrRegion;
    batchRegion_t fwdRegion;
    batchRegion_t bwdRegion;
    batchPos_t wrPos;
    batchPos_t fwdPosIdx;
    batchPos_t bwdPosIdx;

    assign {wrRegion, wrPos} = writeAddr;
    assign {fwdRegion, fwdPosIdx} = fwdAddr;
    assign {bwdRegion, bwdPosIdx} = bwdAddr;

    // The sequencer keeps the write region apart from both read regions
    always_ff @(posedge clkDS) begin
        mem[wrRegion][wrPos] <= in;
        fwdData <= mem[fwdRegion][fwdPosIdx];
        bwdData <= mem[bwdRegion][bwdPosIdx];
    end

endmodule

// ==== recursion/recursionFilter.sv ====
`include "dsm_params.svh"

module recursionFilter (
    input  logic              clkDS,
    input  logic              rst,
    input  dsmPkg::dsmVector_t vector,
    input  logic              restart,
    output dsmPkg::dsmState_t  state
);
    import dsmPkg::*;

    logic [$clog2(`VEC_W+1)-1:0] ones;
    dsmWeight_t weight;
    dsmState_t leak;

    // Ones count of the vector
    always_comb begin
        ones = '0;
        for (int i = 0; i < `VEC_W; i++) begin
            ones = ones + $bits(ones)'(vector[i]);
        end
    end

    // 2 * ones - VEC_W, centred on zero
    assign weight = dsmWeight_t'({ones, 1'b0}) - dsmWeight_t'(`VEC_W);

    assign leak = state >>> `LEAK_SHIFT;

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            state <= '0;
        end else if (restart) begin
            // New run starts from the weight alone
            state <= dsmState_t'(weight);
        end else begin
            state <= state - leak + dsmState_t'(weight);
        end
    end

endmodule

// ==== recursion/resultCombiner.sv ====
`include "dsm_params.svh"

module resultCombiner (
    input  logic              clkDS,
    input  logic              rst,
    input  dsmPkg::dsmState_t  fwdState,
    input  dsmPkg::dsmState_t  bwdState,
    input  batchPkg::batchPos_t fwdPos,
    input  batchPkg::batchPos_t bwdPos,
    input  logic              resBank,
    output dsmPkg::dsmOut_t    out
);
    import dsmPkg::*;

    localparam dsmState_t ResMax = dsmState_t'((1 << (`OUT_W - 1)) - 1);
    localparam dsmState_t ResMin = dsmState_t'(-(1 << (`OUT_W - 1)));

    // Bank resBank fills while the other bank is read back
    dsmResult_t resMem [2][`BATCH_LEN];

    dsmResult_t fwdScaled;
    dsmResult_t bwdScaled;
    dsmResult_t bwdStored;
    dsmResult_t sumReg;
    dsmState_t sumWide;

    function automatic dsmResult_t saturate(input dsmState_t value);
        if (value > ResMax) begin
            return dsmResult_t'(ResMax);
        end else if (value < ResMin) begin
            return dsmResult_t'(ResMin);
        end
        return dsmResult_t'(value);
    endfunction

    assign fwdScaled = saturate(fwdState >>> `OUT_SHIFT);
    assign bwdScaled = saturate(bwdState >>> `OUT_SHIFT);

    // Backward value of the batch now running forward
    assign bwdStored = resMem[~resBank][fwdPos];

    assign sumWide = dsmState_t'(fwdScaled) + dsmState_t'(bwdStored);

    // Backward states arrive in reversed position order
    always_ff @(posedge clkDS) begin
        resMem[resBank][bwdPos] <= bwdScaled;
    end

    always_ff @(posedge clkDS) begin
        sumReg <= saturate(sumWide);
    end

    // Offset binary by flipping the sign bit
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            out <= '0;
        end else begin
            out <= dsmOut_t'({~sumReg[`OUT_W-1], sumReg[`OUT_W-2:0]});
        end
    end

endmodule

// ==== rtl/batchEstimator.sv ====
module batchEstimator (
    input  logic              clkDS,
    input  logic              rst,
    input  dsmPkg::dsmVector_t in,
    output dsmPkg::dsmOut_t    out,
    output logic              valid
);
    import dsmPkg::*;
    import batchPkg::*;

    sampleAddr_t writeAddr;
    sampleAddr_t fwdAddr;
    sampleAddr_t bwdAddr;
    batchPos_t seqFwdPos;
    batchPos_t seqBwdPos;
    batchPos_t fwdPosDly;
    batchPos_t bwdPosDly;
    logic backRestart;
    logic restartDly;
    logic seqBank;
    logic bankDly;
    logic fwdRestart;
    batchPeriod_t fillCnt;
    dsmVector_t fwdData;
    dsmVector_t bwdData;
    dsmState_t fwdState;
    dsmState_t bwdState;
    dsmOut_t combOut;

    batchSequencer batchSequencer_i (
        .clkDS       (clkDS),
        .rst         (rst),
        .writeAddr   (writeAddr),
        .fwdAddr     (fwdAddr),
        .bwdAddr     (bwdAddr),
        .fwdPos      (seqFwdPos),
        .bwdPos      (seqBwdPos),
        .backRestart (backRestart),
        .resBank     (seqBank),
        .valid       (valid)
    );

    sampleBuffer sampleBuffer_i (
        .clkDS     (clkDS),
        .writeAddr (writeAddr),
        .in        (in),
        .fwdAddr   (fwdAddr),
        .bwdAddr   (bwdAddr),
        .fwdData   (fwdData),
        .bwdData   (bwdData)
    );

    // Restart lines up with the read data, positions and bank with the filter output
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            restartDly <= 1'b0;
            fwdPosDly <= '0;
            bwdPosDly <= '0;
            bankDly <= 1'b0;
        end else begin
            restartDly <= backRestart;
            fwdPosDly <= seqFwdPos;
            bwdPosDly <= seqBwdPos;
            bankDly <= seqBank;
        end
    end

    // Third batch start in the data stream carries the first real forward sample
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            fillCnt <= '0;
        end else if (restartDly && fillCnt != 2'd3) begin
            fillCnt <= fillCnt + 2'd1;
        end
    end

    // Forward state holds only the newest weight until real data arrives,
    // then runs without restart
    assign fwdRestart = (fillCnt != 2'd3);

    recursionFilter fwdFilter (
        .clkDS   (clkDS),
        .rst     (rst),
        .vector  (fwdData),
        .restart (fwdRestart),
        .state   (fwdState)
    );

    recursionFilter bwdFilter (
        .clkDS   (clkDS),
        .rst     (rst),
        .vector  (bwdData),
        .restart (restartDly),
        .state   (bwdState)
    );

    resultCombiner resultCombiner_i (
        .clkDS    (clkDS),
        .rst      (rst),
        .fwdState (fwdState),
        .bwdState (bwdState),
        .fwdPos   (fwdPosDly),
        .bwdPos   (bwdPosDly),
        .resBank  (bankDly),
        .out      (combOut)
    );

    // Output reads zero until the pipeline is filled
    assign out = valid ? combOut : '0;

endmodule

// ==== sim/tbBatchEstimator.sv ====
`include "dsm_params.svh"

module tbBatchEstimator;
    timeunit 1ns;
    timeprecision 1ps;

    import dsmPkg::*;

    localparam int BatchLen = `BATCH_LEN;
    localparam int Latency = 2 * BatchLen + 4;
    localparam int TestLen = 4 * BatchLen;
    localparam int NumTests = 6;
    localparam int ResetCycles = 4;
    localparam int ResMax = (1 << (`OUT_W - 1)) - 1;
    localparam int ResMin = -(1 << (`OUT_W - 1));
    localparam dsmOut_t SignBit = dsmOut_t'(1 << (`OUT_W - 1));
    // Each test with its drain and alignment plus the partial batch before the mid-run reset
    localparam int CycleLimit =
        2 * (NumTests * (TestLen + Latency + BatchLen) + 2 * BatchLen + 2 * ResetCycles);
    // Zero weight keeps the stream quiet while outputs drain
    localparam dsmVector_t FillVec = dsmVector_t'(8'h0F);

    logic clkDS;
    logic rst;
    dsmVector_t vecIn;
    dsmOut_t estOut;
    logic estValid;

    int seed;
    int cycleCount;
    int errCount;
    int checkCount;
    int testsRun;
    int testErrStart;
    string curTest;

    // Reference model of the current run since reset
    dsmVector_t vecHist[$];
    int fwdHist[$];
    dsmState_t fwdModel;
    int sampleCount;
    int outIdx;
    int lowCycles;

    batchEstimator batchEstimator_i (
        .clkDS (clkDS),
        .rst   (rst),
        .in    (vecIn),
        .out   (estOut),
        .valid (estValid)
    );

    initial begin
        clkDS = 1'b0;
        forever #50 clkDS = ~clkDS;
    end

    always @(posedge clkDS) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", CycleLimit);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic int weightOf(input dsmVector_t v);
        int ones;
        ones = 0;
        for (int i = 0; i < `VEC_W; i++) begin
            ones = ones + int'(v[i]);
        end
        return 2 * ones - `VEC_W;
    endfunction

    function automatic dsmState_t leakStep(input dsmState_t s, input int w);
        return s - (s >>> `LEAK_SHIFT) + dsmState_t'(w);
    endfunction

    function automatic int saturateResult(input int v);
        if (v > ResMax) begin
            return ResMax;
        end else if (v < ResMin) begin
            return ResMin;
        end
        return v;
    endfunction

    // Backward run restarts at the last position of the batch holding sample m
    function automatic dsmOut_t expectedOut(input int m);
        int batchEnd;
        int fs;
        int bs;
        int sum;
        dsmState_t bwd;
        batchEnd = (m / BatchLen) * BatchLen + BatchLen - 1;
        bwd = '0;
        for (int i = batchEnd; i >= m; i--) begin
            if (i == batchEnd) begin
                bwd = dsmState_t'(weightOf(vecHist[i]));
            end else begin
                bwd = leakStep(bwd, weightOf(vecHist[i]));
            end
        end
        fs = saturateResult(fwdHist[m] >>> `OUT_SHIFT);
        bs = saturateResult(int'(bwd) >>> `OUT_SHIFT);
        sum = saturateResult(fs + bs);
        return dsmOut_t'(sum) ^ SignBit;
    endfunction

    task automatic checkOut(input dsmOut_t expected, input dsmOut_t actual);
        checkCount++;
        if (actual !== expected) begin
            errCount++;
            $display("FAIL %s: out expected %h, actual %h (output %0d)",
                     curTest, expected, actual, outIdx);
        end
    endtask

    task automatic checkValid(input logic expected, input logic actual);
        checkCount++;
        if (actual !== expected) begin
            errCount++;
            $display("FAIL %s: valid expected %b, actual %b (sample count %0d)",
                     curTest, expected, actual, sampleCount);
        end
    endtask

    task automatic checkLatency();
        checkCount++;
        if (lowCycles != Latency) begin
            errCount++;
            $display("FAIL %s: valid low cycles expected %0d, actual %0d",
                     curTest, Latency, lowCycles);
        end
    endtask

    // Outputs are stable at the falling edge
    task automatic sampleOutputs();
        logic expValid;
        expValid = (sampleCount >= Latency);
        checkValid(expValid, estValid);
        if (!estValid) begin
            lowCycles++;
            checkOut('0, estOut);
        end else if (expValid) begin
            checkOut(expectedOut(outIdx), estOut);
            outIdx++;
        end
    endtask

    task automatic driveSample(input dsmVector_t v);
        vecIn = v;
        vecHist.push_back(v);
        fwdModel = leakStep(fwdModel, weightOf(v));
        fwdHist.push_back(int'(fwdModel));
        sampleCount++;
        @(negedge clkDS);
        sampleOutputs();
    endtask

    task automatic applyReset(input bit checkClear);
        rst = 1'b0;
        if (checkClear) begin
            #1;
            checkValid(1'b0, estValid);
            checkOut('0, estOut);
        end
        vecHist.delete();
        fwdHist.delete();
        fwdModel = '0;
        sampleCount = 0;
        outIdx = 0;
        lowCycles = 0;
        repeat (ResetCycles) @(negedge clkDS);
        rst = 1'b1;
        sampleOutputs();
    endtask

    // Run on until every driven test sample has been compared, then realign to a batch
    task automatic drainOutputs();
        int target;
        target = sampleCount;
        while (outIdx < target) begin
            driveSample(FillVec);
        end
        while (sampleCount % BatchLen != 0) begin
            driveSample(FillVec);
        end
    endtask

    task automatic startTest(input string name);
        curTest = name;
        testErrStart = errCount;
    endtask

    task automatic finishTest();
        testsRun++;
        $display("Test %s finished with %0d errors", curTest, errCount - testErrStart);
    endtask

    task automatic resetLatencyTest();
        startTest("resetLatency");
        repeat (TestLen) driveSample(FillVec);
        checkLatency();
        drainOutputs();
        finishTest();
    endtask

    task automatic allOnesTest();
        startTest("allOnes");
        repeat (TestLen) driveSample(dsmVector_t'(8'hFF));
        drainOutputs();
        finishTest();
    endtask

    // Weights +4 and -4 in turn
    task automatic alternatingTest();
        startTest("alternating");
        for (int i = 0; i < TestLen; i++) begin
            driveSample((i % 2 == 0) ? dsmVector_t'(8'h3F) : dsmVector_t'(8'h03));
        end
        drainOutputs();
        finishTest();
    endtask

    // Stream is batch aligned here, so the step lands on a batch start
    task automatic stepBoundaryTest();
        startTest("stepBoundary");
        repeat (BatchLen) driveSample(dsmVector_t'(8'h01));
        repeat (TestLen - BatchLen) driveSample(dsmVector_t'(8'hFF));
        drainOutputs();
        finishTest();
    endtask

    task automatic randomBatchesTest();
        startTest("randomBatches");
        repeat (TestLen) driveSample(dsmVector_t'($random(seed)));
        drainOutputs();
        finishTest();
    endtask

    task automatic midRunResetTest();
        startTest("midRunReset");
        repeat (BatchLen + BatchLen / 2) driveSample(dsmVector_t'($random(seed)));
        applyReset(1'b1);
        repeat (TestLen) driveSample(dsmVector_t'($random(seed)));
        checkLatency();
        drainOutputs();
        finishTest();
    endtask

    initial begin
        seed = 32'h1ee55935;
        rst = 1'b0;
        vecIn = '0;
        cycleCount = 0;
        errCount = 0;
        checkCount = 0;
        testsRun = 0;
        testErrStart = 0;
        curTest = "init";
        applyReset(1'b0);
        resetLatencyTest();
        allOnesTest();
        alternatingTest();
        stepBoundaryTest();
        randomBatchesTest();
        midRunResetTest();
        $display("Tests: %0d, checks: %0d, errors: %0d", testsRun, checkCount, errCount);
        if (errCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+common
common/dsmPkg.sv
common/batchPkg.sv
rtl/batchSequencer.sv
rtl/sampleBuffer.sv
recursion/recursionFilter.sv
recursion/resultCombiner.sv
rtl/batchEstimator.sv
sim/tbBatchEstimator.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the batch estimator testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --timescale 1ns/1ps \
    -f vlog.f --top-module tbBatchEstimator \
    -Mdir "$OBJ" -o tbBatchEstimator
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$OBJ/tbBatchEstimator" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
    echo "No pass line found in $LOG"
    exit 1
fi
exit 0
